// File: common/icache_pkg.sv
// icache shared types, line geometry constants and controller state encoding
package icache_pkg;

    // address and line geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int OFFSET_W       = 4;      // byte offset inside a 16-byte line
    localparam int WORD_LSB       = 2;      // addr[3:2] picks the word
    localparam int WORD_SEL_W     = 2;

    // fetch address from the core
    typedef logic [ADDR_W-1:0] addr_t;

    // one instruction word
    typedef logic [WORD_W-1:0] word_t;

    // full line, word 0 sits in bits 31:0
    typedef logic [LINE_W-1:0] line_t;

    // controller FSM
    typedef enum logic [2:0] {
        IC_IDLE      = 3'd0,    // one cycle after reset
        IC_ACCESS    = 3'd1,    // lookup on fetch
        IC_WAIT_L2   = 3'd2,    // miss, L2 still busy
        IC_L2_ACCESS = 3'd3,    // request out, waiting for rdy
        IC_REFILL    = 3'd4     // replay lookup after line write
    } ic_state_t;

endpackage

// File: icache/icache_way_ram.sv
// icache way store: per-set valid bits, tag array and line data array
module icache_way_ram import icache_pkg::*; #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W,
    localparam int SETS  = 1 << INDEX_W
) (
    input  logic               clk_tmp,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] index,
    input  logic               we,
    input  logic [TAG_W-1:0]   wr_tag,
    input  line_t              wr_line,
    output logic               valid,
    output logic [TAG_W-1:0]   tag,
    output line_t              line
);

    logic [SETS-1:0]  valid_q;              // cleared by reset
    logic [TAG_W-1:0] tag_mem  [SETS];
    line_t            line_mem [SETS];

    // combinational read, same index as the write
    assign valid = valid_q[index];
    assign tag   = tag_mem[index];
    assign line  = line_mem[index];

    always_ff @(posedge clk_tmp or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (we) begin
            valid_q[index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk_tmp) begin
        if (we) begin
            tag_mem[index]  <= wr_tag;
            line_mem[index] <= wr_line;
        end
    end

endmodule

// File: icache/icache_lru.sv
// icache replacement store: one LRU bit per set
module icache_lru #(
    parameter int INDEX_W = 8,
    localparam int SETS = 1 << INDEX_W
) (
    input  logic               clk_tmp,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] index,
    input  logic               hit_pulse,
    input  logic               fill_pulse,
    input  logic               use_way,
    output logic               victim
);

    logic [SETS-1:0] lru_q;                 // names the way to evict next

    assign victim = lru_q[index];

    // the way just touched becomes most recent
    always_ff @(posedge clk_tmp or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (hit_pulse || fill_pulse) begin
            lru_q[index] <= ~use_way;
        end
    end

endmodule

// File: icache/icache_ctrl.sv
// icache controller: tag compare, word select, miss FSM, victim choice and way write strobes
module icache_ctrl import icache_pkg::*; #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W
) (
    input  logic               clk_tmp,
    input  logic               rst_n,
    // core side
    input  logic               fetch,
    input  addr_t              if_addr,
    output word_t              instr,
    output logic               instr_valid,
    output logic               miss_stall,
    // L2 side
    input  logic               l2_busy,
    input  logic               l2_rdy,
    input  line_t              l2_line,
    output logic               l2_req,
    output addr_t              l2_addr,
    // way stores
    output logic [INDEX_W-1:0] index,
    input  logic               valid0,
    input  logic               valid1,
    input  logic [TAG_W-1:0]   tag0,
    input  logic [TAG_W-1:0]   tag1,
    input  line_t              line0,
    input  line_t              line1,
    output logic [1:0]         way_we,
    output logic [TAG_W-1:0]   wr_tag,
    output line_t              wr_line,
    // LRU store
    input  logic               victim,
    output logic               hit_pulse,
    output logic               fill_pulse,
    output logic               use_way
);

    ic_state_t             state;
    addr_t                 addr_q;      // fetch address kept for the miss
    addr_t                 lk_addr;
    logic [TAG_W-1:0]      lk_tag;
    logic [WORD_SEL_W-1:0] word_sel;
    logic                  lookup_en;
    logic                  hit0;
    logic                  hit1;
    logic                  hit;
    logic                  hit_way;
    logic                  fill_way;
    logic                  fill_now;
    line_t                 hit_line;

    // live address on a new fetch, held copy everywhere else
    assign lk_addr  = (state == IC_ACCESS) ? if_addr : addr_q;
    assign index    = lk_addr[OFFSET_W +: INDEX_W];
    assign lk_tag   = lk_addr[ADDR_W-1 -: TAG_W];
    assign word_sel = lk_addr[WORD_LSB +: WORD_SEL_W];

    // new fetch, or replay once the refilled line is in place
    assign lookup_en = (state == IC_ACCESS && fetch) || (state == IC_REFILL);

    assign hit0     = valid0 && (tag0 == lk_tag);
    assign hit1     = valid1 && (tag1 == lk_tag);
    assign hit      = hit0 || hit1;
    assign hit_way  = !hit0;                    // way 0 wins a double hit
    assign hit_line = hit0 ? line0 : line1;

    // empty way 0, then empty way 1, then LRU pick
    always_comb begin
        if (!valid0) begin
            fill_way = 1'b0;
        end else if (!valid1) begin
            fill_way = 1'b1;
        end else begin
            fill_way = victim;
        end
    end

    // line write lands on the l2_rdy edge
    assign fill_now = (state == IC_L2_ACCESS) && l2_rdy;
    assign way_we   = {fill_now && fill_way, fill_now && !fill_way};
    assign wr_tag   = lk_tag;
    assign wr_line  = l2_line;

    assign hit_pulse  = lookup_en && hit;
    assign fill_pulse = fill_now;
    assign use_way    = fill_now ? fill_way : hit_way;

    assign l2_addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // control FSM
    always_ff @(posedge clk_tmp or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IC_IDLE;
            instr_valid <= 1'b0;
            miss_stall  <= 1'b0;
            l2_req      <= 1'b0;
        end else begin
            instr_valid <= 1'b0;                // one-cycle pulse
            case (state)
                IC_IDLE: begin
                    state <= IC_ACCESS;
                end
                IC_ACCESS, IC_REFILL: begin
                    if (lookup_en) begin
                        if (hit) begin
                            instr_valid <= 1'b1;
                            miss_stall  <= 1'b0;
                            state       <= IC_ACCESS;
                        end else begin
                            miss_stall <= 1'b1;
                            if (l2_busy) begin
                                state <= IC_WAIT_L2;
                            end else begin
                                l2_req <= 1'b1;
                                state  <= IC_L2_ACCESS;
                            end
                        end
                    end
                end
                IC_WAIT_L2: begin
                    if (!l2_busy) begin
                        l2_req <= 1'b1;
                        state  <= IC_L2_ACCESS;
                    end
                end
                IC_L2_ACCESS: begin
                    if (l2_rdy) begin
                        l2_req <= 1'b0;
                        state  <= IC_REFILL;
                    end
                end
                default: begin
                    state <= IC_IDLE;
                end
            endcase
        end
    end

    // address and instruction payload
    always_ff @(posedge clk_tmp) begin
        if (state == IC_ACCESS && fetch) begin
            addr_q <= if_addr;
        end
        if (lookup_en && hit) begin
            instr <= hit_line[word_sel*WORD_W +: WORD_W];
        end
    end

endmodule

// File: verilog/icache_top.sv
// icache top level: controller, two way stores and LRU store
module icache_top import icache_pkg::*; #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W
) (
    input  logic  clk_tmp,
    input  logic  rst_n,
    input  logic  fetch,
    input  addr_t if_addr,
    output word_t instr,
    output logic  instr_valid,
    output logic  miss_stall,
    input  logic  l2_busy,
    output logic  l2_req,
    output addr_t l2_addr,
    input  logic  l2_rdy,
    input  line_t l2_line
);

    logic [INDEX_W-1:0] index;
    logic               valid0;
    logic               valid1;
    logic [TAG_W-1:0]   tag0;
    logic [TAG_W-1:0]   tag1;
    line_t              line0;
    line_t              line1;
    logic [1:0]         way_we;         // one strobe per way
    logic [TAG_W-1:0]   wr_tag;
    line_t              wr_line;
    logic               hit_pulse;
    logic               fill_pulse;
    logic               use_way;
    logic               victim;

    icache_ctrl #(
        .INDEX_W (INDEX_W)
    ) icache_ctrl_i (
        .clk_tmp     (clk_tmp),
        .rst_n       (rst_n),
        .fetch       (fetch),
        .if_addr     (if_addr),
        .instr       (instr),
        .instr_valid (instr_valid),
        .miss_stall  (miss_stall),
        .l2_busy     (l2_busy),
        .l2_rdy      (l2_rdy),
        .l2_line     (l2_line),
        .l2_req      (l2_req),
        .l2_addr     (l2_addr),
        .index       (index),
        .valid0      (valid0),
        .valid1      (valid1),
        .tag0        (tag0),
        .tag1        (tag1),
        .line0       (line0),
        .line1       (line1),
        .way_we      (way_we),
        .wr_tag      (wr_tag),
        .wr_line     (wr_line),
        .victim      (victim),
        .hit_pulse   (hit_pulse),
        .fill_pulse  (fill_pulse),
        .use_way     (use_way)
    );

    icache_way_ram #(
        .INDEX_W (INDEX_W)
    ) way0_i (
        .clk_tmp (clk_tmp),
        .rst_n   (rst_n),
        .index   (index),
        .we      (way_we[0]),
        .wr_tag  (wr_tag),
        .wr_line (wr_line),
        .valid   (valid0),
        .tag     (tag0),
        .line    (line0)
    );

    icache_way_ram #(
        .INDEX_W (INDEX_W)
    ) way1_i (
        .clk_tmp (clk_tmp),
        .rst_n   (rst_n),
        .index   (index),
        .we      (way_we[1]),
        .wr_tag  (wr_tag),
        .wr_line (wr_line),
        .valid   (valid1),
        .tag     (tag1),
        .line    (line1)
    );

    icache_lru #(
        .INDEX_W (INDEX_W)
    ) icache_lru_i (
        .clk_tmp    (clk_tmp),
        .rst_n      (rst_n),
        .index      (index),
        .hit_pulse  (hit_pulse),
        .fill_pulse (fill_pulse),
        .use_way    (use_way),
        .victim     (victim)
    );

endmodule

// File: dv/icache_asserts.sv
// icache controller assertions: L2 request protocol and way write strobes
module icache_asserts import icache_pkg::*; (
    input logic       clk_tmp,
    input logic       rst_n,
    input ic_state_t  state,
    input logic       instr_valid,
    input logic       miss_stall,
    input logic       l2_busy,
    input logic       l2_req,
    input logic [1:0] way_we
);

    req_with_stall: assert property (@(posedge clk_tmp) disable iff (!rst_n)
        l2_req |-> miss_stall)
        else $error("l2_req high without miss_stall");

    refill_replay_hits: assert property (@(posedge clk_tmp) disable iff (!rst_n)
        (state == IC_REFILL) |=> (instr_valid && !miss_stall))
        else $error("replay after a refill did not deliver the instruction");

    no_valid_on_fill: assert property (@(posedge clk_tmp) disable iff (!rst_n)
        !(instr_valid && (way_we != 2'b00)))
        else $error("instr_valid high during a refill write");

    req_not_busy: assert property (@(posedge clk_tmp) disable iff (!rst_n)
        $rose(l2_req) |-> !$past(l2_busy))
        else $error("l2_req rose while l2_busy was high");

    one_way_write: assert property (@(posedge clk_tmp) disable iff (!rst_n)
        way_we != 2'b11)
        else $error("both way write strobes high");

endmodule

bind icache_ctrl icache_asserts icache_asserts_i (
    .clk_tmp     (clk_tmp),
    .rst_n       (rst_n),
    .state       (state),
    .instr_valid (instr_valid),
    .miss_stall  (miss_stall),
    .l2_busy     (l2_busy),
    .l2_req      (l2_req),
    .way_we      (way_we)
);

// File: dv/tb_icache.sv
// icache testbench: clock, reset, stimulus reader, L2 model, reference cache model and checks
module tb_icache
    import icache_pkg::*;
();

    localparam int INDEX_W = 8;
    localparam int SETS    = 1 << INDEX_W;
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
    localparam int MAX_REC = 64;
    localparam int REC_CYC = 200;                   // cycle budget per record
    localparam int L2_LAT  = 3;                     // request to rdy in cycles
    localparam int HOLD    = 2;                     // drive skew after the rising edge
    localparam logic [31:0] SEED = 32'h2604_3bd9;

    logic  clk_tmp;
    logic  rst_n;
    logic  fetch;
    addr_t if_addr;
    word_t instr;
    logic  instr_valid;
    logic  miss_stall;
    logic  l2_busy;
    logic  l2_req;
    addr_t l2_addr;
    logic  l2_rdy;
    line_t l2_line;

    logic [31:0]      stim [0:3*MAX_REC];           // record count then address/delay/hit triples
    int               n_rec;
    bit               loaded;
    addr_t            cur_addr;
    int               req_count;
    int               err_value;
    int               err_proto;
    int               err_l2;
    logic             model_valid [2][SETS];
    logic [TAG_W-1:0] model_tag   [2][SETS];
    logic             model_lru   [SETS];           // way to evict next

    icache_top #(
        .INDEX_W (INDEX_W)
    ) icache_top_i (
        .clk_tmp     (clk_tmp),
        .rst_n       (rst_n),
        .fetch       (fetch),
        .if_addr     (if_addr),
        .instr       (instr),
        .instr_valid (instr_valid),
        .miss_stall  (miss_stall),
        .l2_busy     (l2_busy),
        .l2_req      (l2_req),
        .l2_addr     (l2_addr),
        .l2_rdy      (l2_rdy),
        .l2_line     (l2_line)
    );

    initial begin
        clk_tmp = 1'b0;
        forever #20 clk_tmp = ~clk_tmp;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // L2 contents as an xorshift chain from the seeded line address
    function automatic line_t make_line(input addr_t a);
        logic [31:0] s;
        line_t       ln;
        s = SEED ^ {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            s = xorshift32(s);
            ln[k*WORD_W +: WORD_W] = s;
        end
        return ln;
    endfunction

    // reference tags, valid bits and LRU with the cache's victim order
    task automatic model_lookup(input addr_t a, output bit hit);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        int                 way;
        idx = a[OFFSET_W +: INDEX_W];
        tg  = a[ADDR_W-1 -: TAG_W];
        hit = 1'b0;
        if (model_valid[0][idx] && model_tag[0][idx] == tg) begin
            hit = 1'b1;
            way = 0;
        end else if (model_valid[1][idx] && model_tag[1][idx] == tg) begin
            hit = 1'b1;
            way = 1;
        end else begin
            if (!model_valid[0][idx]) begin
                way = 0;
            end else if (!model_valid[1][idx]) begin
                way = 1;
            end else begin
                way = model_lru[idx] ? 1 : 0;
            end
            model_valid[way][idx] = 1'b1;
            model_tag[way][idx]   = tg;
        end
        model_lru[idx] = (way == 0);                // other way goes next
    endtask

    task automatic run_record(input int r);
        addr_t  a;
        int     delay;
        bit     exp_hit;
        bit     model_hit;
        int     req_before;
        int     cycles;
        line_t  ln;
        word_t  exp_word;
        string  name;
        a        = stim[1 + 3*r];
        delay    = int'(stim[2 + 3*r]);
        exp_hit  = stim[3 + 3*r][0];
        name     = $sformatf("rec%0d@%08h", r, a);
        model_lookup(a, model_hit);
        if (model_hit != exp_hit) begin
            $display("%s: stimulus file and reference model disagree on hit or miss", name);
            err_proto++;
        end
        ln         = make_line(a);
        exp_word   = ln[int'(a[3:2])*WORD_W +: WORD_W];
        req_before = req_count;
        cur_addr   = a;
        @(posedge clk_tmp);
        #(HOLD);
        fetch   = 1'b1;
        if_addr = a;
        l2_busy = (delay > 0);
        @(posedge clk_tmp);
        #(HOLD);
        fetch  = 1'b0;
        cycles = 0;
        while (!instr_valid && cycles < REC_CYC) begin
            if (l2_busy && l2_req) begin
                $display("%s: l2_req went high while l2_busy was high", name);
                err_proto++;
            end
            if (!exp_hit && !miss_stall) begin
                $display("%s: miss_stall low while the miss is served", name);
                err_proto++;
            end
            if (cycles + 1 >= delay) begin
                l2_busy = 1'b0;                     // busy seen for delay edges
            end
            @(posedge clk_tmp);
            #(HOLD);
            cycles++;
        end
        l2_busy = 1'b0;
        if (!instr_valid) begin
            $display("%s: no instr_valid within %0d cycles of the fetch", name, REC_CYC);
            err_proto++;
        end else begin
            if (instr !== exp_word) begin
                $display("FAILED %s instr: expected %08h, actual %08h", name, exp_word, instr);
                err_value++;
            end
            if (miss_stall) begin
                $display("%s: miss_stall still high together with instr_valid", name);
                err_proto++;
            end
            if (exp_hit && cycles != 0) begin
                $display("FAILED %s hit latency: expected 1, actual %0d", name, cycles + 1);
                err_value++;
            end
            if (req_count - req_before != (exp_hit ? 0 : 1)) begin
                $display("FAILED %s l2 requests: expected %0d, actual %0d", name,
                         exp_hit ? 0 : 1, req_count - req_before);
                err_value++;
            end
        end
    endtask

    // L2 model answering each request with one rdy pulse
    initial begin : l2_model
        l2_rdy    = 1'b0;
        l2_line   = '0;
        req_count = 0;
        err_l2    = 0;
        forever begin
            @(posedge clk_tmp);
            #(HOLD);
            if (l2_req) begin
                req_count++;
                if (l2_addr !== {cur_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}) begin
                    $display("FAILED l2_addr: expected %08h, actual %08h",
                             {cur_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}, l2_addr);
                    err_l2++;
                end
                repeat (L2_LAT) @(posedge clk_tmp);
                #(HOLD);
                l2_line = make_line(l2_addr);
                l2_rdy  = 1'b1;
                @(posedge clk_tmp);
                #(HOLD);
                l2_rdy  = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_rec * REC_CYC + 100) @(posedge clk_tmp);
        $display("watchdog expired, the run did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        fetch     = 1'b0;
        if_addr   = '0;
        l2_busy   = 1'b0;
        rst_n     = 1'b0;
        err_value = 0;
        err_proto = 0;
        cur_addr  = '0;
        for (int s = 0; s < SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s]      = 1'b0;
        end
        $readmemh("dv/icache_input.txt", stim);
        n_rec = int'(stim[0]);
        if (n_rec < 1 || n_rec > MAX_REC) begin
            $display("stimulus file holds a bad record count %0d", n_rec);
            err_proto++;
            n_rec = 0;
        end
        loaded = 1'b1;
        repeat (10) @(posedge clk_tmp);
        #(HOLD);
        rst_n = 1'b1;
        repeat (3) @(posedge clk_tmp);
        #(HOLD);
        if (instr_valid || miss_stall || l2_req) begin
            $display("outputs active after reset before any fetch");
            err_proto++;
        end
        for (int r = 0; r < n_rec; r++) begin
            run_record(r);
        end
        repeat (2) @(posedge clk_tmp);
        $display("%0d records, %0d value errors, %0d protocol errors, %0d L2 errors",
                 n_rec, err_value, err_proto, err_l2);
        if (err_value + err_proto + err_l2 == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: dv/icache_input.txt
// icache fetch stimulus: first word is the record count, then one record per line
// columns: fetch address, L2 busy delay in cycles, expected hit (1) or miss (0)
1f
// cold miss, hits on the same line, second way, LRU eviction in set 00
00001000 0 0
00001004 0 1
00001008 0 1
0000100c 0 1
00002000 0 0
00001004 0 1
00002008 0 1
00001000 0 1
00003000 0 0
00001008 0 1
00002004 0 0
0000300c 0 0
00002000 0 1
// L2 back-pressure and replacement in set 05
00004050 5 0
00004054 0 1
00005050 3 0
0000405c 0 1
00006058 7 0
00005050 2 0
00006054 0 1
00005058 0 1
// scattered tags and sets
12345670 0 0
12345678 0 1
abcdeff0 1 0
abcdeffc 0 1
80000ff4 0 0
1234567c 0 1
abcdeff4 0 1
80000ff0 0 1
0000100c 0 0
00002004 0 1

// File: sources.f
common/icache_pkg.sv
icache/icache_way_ram.sv
icache/icache_lru.sv
icache/icache_ctrl.sv
verilog/icache_top.sv
dv/icache_asserts.sv
dv/tb_icache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_icache
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
